// ==== Makefile ====
SOURCES := $(shell cat src.f)

.PHONY: all run clean

all: obj_dir/Vcache2_tb

obj_dir/Vcache2_tb: src.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module cache2_tb -f src.f

run: obj_dir/Vcache2_tb
	./obj_dir/Vcache2_tb

clean:
	rm -rf obj_dir

// ==== dv/cache2_tb.sv ====
/*
  Directed testbench for the LLC with a random-latency memory model.
  A reference model of tags, dirty bits and PLRU predicts every pmem transfer.
  Offset bits of request addresses are don't-care; lines are whole.
*/

`timescale 1ns/1ps

module cache2_tb import llc_pkg::*; import rv32i_types::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 300;
    localparam int NUM_REQUESTS = NUM_RANDOM + 21;
    localparam int TIMEOUT_NS   = NUM_REQUESTS * 40 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

    logic         clk;
    logic         rst_n_i;
    rv32i_word    mem_address_i;
    llc_cacheline mem_wdata_i;
    logic         mem_read_i;
    logic         mem_write_i;
    llc_cacheline mem_rdata_o;
    logic         mem_resp_o;
    logic         pmem_read_o;
    logic         pmem_write_o;
    llc_cacheline pmem_rdata_i;
    logic         pmem_resp_i;
    llc_cacheline pmem_wdata_o;
    rv32i_word    pmem_address_o;

    // main memory contents and the lines written from the L1 side
    llc_cacheline mem_lines [rv32i_word];
    llc_cacheline cpu_lines [rv32i_word];
    // observed transfers, {is_write, address}
    logic [32:0]  traffic_q [$];
    int           pmem_reads;
    int           pmem_writes;

    // reference copy of the cache state
    llc_tag_t     ref_tag [NUM_SETS][NUM_WAYS];
    logic         ref_valid [NUM_SETS][NUM_WAYS];
    logic         ref_dirty [NUM_SETS][NUM_WAYS];
    plru_bits_t   ref_plru [NUM_SETS];
    int           exp_reads;
    int           exp_writes;

    cache2 dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_line(input string name, input llc_cacheline got,
                              input llc_cacheline exp);
        assert (got == exp) else stop_fail($sformatf("Mismatch at %0t: %s got %h expected %h",
                                                     $time, name, got, exp));
    endtask

    task automatic check_value(input string name, input logic [32:0] got,
                               input logic [32:0] exp);
        assert (got == exp) else stop_fail($sformatf("Mismatch at %0t: %s got %h expected %h",
                                                     $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        assert (got == exp) else stop_fail($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                                     $time, name, got, exp));
    endtask

    function automatic rv32i_word line_address(input llc_tag_t tag, input llc_index_t idx);
        return {tag, idx, {S_OFFSET{1'b0}}};
    endfunction

    function automatic llc_cacheline random_line();
        llc_cacheline line;
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    // filled on first use, mixed with the address so every line differs
    function automatic llc_cacheline memory_line(input rv32i_word addr);
        llc_cacheline line;
        if (!mem_lines.exists(addr)) begin
            for (int w = 0; w < 8; w++) begin
                line[w*32 +: 32] = $urandom ^ (addr + 32'(w));
            end
            mem_lines[addr] = line;
        end
        return mem_lines[addr];
    endfunction

    function automatic llc_cacheline expected_line(input rv32i_word addr);
        if (cpu_lines.exists(addr)) begin
            return cpu_lines[addr];
        end
        return memory_line(addr);
    endfunction

    function automatic llc_way_t victim_way(input llc_index_t idx);
        plru_bits_t bits;
        bits = ref_plru[idx];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!ref_valid[idx][w]) begin
                return llc_way_t'(w);
            end
        end
        if (bits[0]) begin
            return bits[2] ? 2'd3 : 2'd2;
        end
        return bits[1] ? 2'd1 : 2'd0;
    endfunction

    // path bits point away from the way just used
    task automatic touch_way(input llc_index_t idx, input llc_way_t way);
        if (way < 2) begin
            ref_plru[idx][0] = 1'b1;
            ref_plru[idx][1] = (way == 2'd0);
        end else begin
            ref_plru[idx][0] = 1'b0;
            ref_plru[idx][2] = (way == 2'd2);
        end
    endtask

    // memory side, answers after 1 to 4 cycles
    initial begin
        int        delay;
        rv32i_word addr;
        pmem_resp_i  = 1'b0;
        pmem_rdata_i = '0;
        pmem_reads   = 0;
        pmem_writes  = 0;
        forever begin
            @(negedge clk);
            pmem_resp_i = 1'b0;
            if (rst_n_i && (pmem_read_o || pmem_write_o)) begin
                addr  = pmem_address_o;
                delay = $urandom_range(4, 1);
                repeat (delay - 1) @(negedge clk);
                assert (pmem_address_o == addr && (pmem_read_o || pmem_write_o))
                    else stop_fail("pmem request changed before its response");
                assert (addr[S_OFFSET-1:0] == '0)
                    else stop_fail("pmem address is not line aligned");
                traffic_q.push_back({pmem_write_o, addr});
                if (pmem_write_o) begin
                    check_line("pmem_wdata_o", pmem_wdata_o, expected_line(addr));
                    mem_lines[addr] = pmem_wdata_o;
                    pmem_writes++;
                end else begin
                    pmem_rdata_i = memory_line(addr);
                    pmem_reads++;
                end
                pmem_resp_i = 1'b1;
            end
        end
    end

    // one request through the DUT, checked against the reference model
    task automatic access(input logic is_write, input rv32i_word addr,
                          input llc_cacheline wdata, output logic hit);
        llc_index_t   idx;
        llc_tag_t     tag;
        llc_way_t     way;
        rv32i_word    line_addr;
        llc_cacheline exp_rdata;
        logic [32:0]  exp_q [$];
        int           cycles;
        idx       = addr[S_OFFSET +: S_INDEX];
        tag       = addr[S_OFFSET + S_INDEX +: S_TAG];
        line_addr = line_address(tag, idx);
        exp_rdata = expected_line(line_addr);
        hit       = 1'b0;
        way       = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = llc_way_t'(w);
            end
        end
        if (!hit) begin
            way = victim_way(idx);
            if (ref_valid[idx][way] && ref_dirty[idx][way]) begin
                exp_q.push_back({1'b1, line_address(ref_tag[idx][way], idx)});
                exp_writes++;
            end
            exp_q.push_back({1'b0, line_addr});
            exp_reads++;
            ref_tag[idx][way]   = tag;
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = 1'b0;
        end
        touch_way(idx, way);

        @(negedge clk);
        traffic_q.delete();
        mem_address_i = addr;
        mem_wdata_i   = wdata;
        mem_read_i    = !is_write;
        mem_write_i   = is_write;
        cycles        = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!mem_resp_o);
        if (!is_write) begin
            check_line("mem_rdata_o", mem_rdata_o, exp_rdata);
        end
        // the request stays up through the edge that ends the response
        @(negedge clk);
        mem_read_i  = 1'b0;
        mem_write_i = 1'b0;
        assert (!mem_resp_o) else stop_fail("mem_resp_o stayed high for more than one cycle");

        if (is_write) begin
            cpu_lines[line_addr] = wdata;
            ref_dirty[idx][way]  = 1'b1;
        end
        check_count("pmem transfers", traffic_q.size(), exp_q.size());
        foreach (exp_q[i]) begin
            check_value("pmem transfer {write, address}", traffic_q[i], exp_q[i]);
        end
        if (hit) begin
            check_count("hit latency in cycles", cycles, 2);
        end
    endtask

    task automatic test_reset();
        logic hit;
        // falling edge so the asynchronous reset fires
        @(negedge clk);
        rst_n_i = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!mem_resp_o && !pmem_read_o && !pmem_write_o)
                else stop_fail("a response or pmem strobe was high during reset");
        end
        rst_n_i = 1'b1;
        repeat (2) begin
            @(negedge clk);
            assert (!mem_resp_o && !pmem_read_o && !pmem_write_o)
                else stop_fail("a response or pmem strobe was high right after reset");
        end
        for (int i = 0; i < 4; i++) begin
            access(1'b0, 32'h0001_0000 + 32'(i * 32 + 3), '0, hit);
            assert (!hit) else stop_fail("first read after reset was predicted to hit");
        end
    endtask

    task automatic test_read_hit();
        logic hit;
        for (int i = 0; i < 4; i++) begin
            access(1'b0, 32'h0001_0000 + 32'(i * 32 + 17), '0, hit);
            assert (hit) else stop_fail("re-read of a loaded line was not a hit");
        end
    endtask

    task automatic test_write_hit();
        logic hit;
        access(1'b1, 32'h0001_0020, random_line(), hit);
        assert (hit) else stop_fail("write to a resident line was not a hit");
        access(1'b0, 32'h0001_0020, '0, hit);
        assert (hit) else stop_fail("read after a write hit was not a hit");
    endtask

    task automatic test_evict();
        logic hit;
        int   writes_before;
        writes_before = pmem_writes;
        // five tags in set 5, even ones written
        for (int k = 0; k < 5; k++) begin
            access(k % 2 == 0, line_address(llc_tag_t'(32'h200 + k), 3'd5), random_line(), hit);
        end
        for (int k = 0; k < 5; k++) begin
            access(1'b0, line_address(llc_tag_t'(32'h200 + k), 3'd5), '0, hit);
        end
        access(1'b1, line_address(llc_tag_t'(32'h201), 3'd5), random_line(), hit);
        assert (pmem_writes > writes_before)
            else stop_fail("no dirty victim was written back in the eviction test");
    endtask

    task automatic test_random_mix();
        logic       hit;
        logic       is_write;
        llc_tag_t   tag;
        llc_index_t idx;
        rv32i_word  addr;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            tag      = llc_tag_t'(32'h300 + $urandom_range(15, 0));
            idx      = llc_index_t'($urandom_range(7, 0));
            is_write = 1'($urandom_range(1, 0));
            addr     = line_address(tag, idx) | $urandom_range(31, 0);
            access(is_write, addr, random_line(), hit);
        end
    endtask

    initial begin
        #TIMEOUT_NS;
        stop_fail("watchdog timeout, the DUT stopped answering requests");
    end

    initial begin
        void'($urandom(32'hf1baac6d));
        rst_n_i       = 1'b1;
        mem_address_i = '0;
        mem_wdata_i   = '0;
        mem_read_i    = 1'b0;
        mem_write_i   = 1'b0;
        exp_reads     = 0;
        exp_writes    = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        test_reset();
        test_read_hit();
        test_write_hit();
        test_evict();
        test_random_mix();
        check_count("pmem read count", pmem_reads, exp_reads);
        check_count("pmem write count", pmem_writes, exp_writes);
        $display("TEST OK");
        $finish;
    end

endmodule : cache2_tb

// ==== rtl/cache2.sv ====
/*
  Second-level cache between the L1 data cache and the cacheline adaptor.
  4-way, 8 sets, 32-byte lines, write-back, write-allocate, blocking.
  Full-line transfers only; there are no byte enables on the L1 side.
*/

`timescale 1ns/1ps

module cache2 import rv32i_types::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    // L1 side
    input  rv32i_word    mem_address_i,
    input  llc_cacheline mem_wdata_i,
    input  logic         mem_read_i,
    input  logic         mem_write_i,
    output llc_cacheline mem_rdata_o,
    output logic         mem_resp_o,
    // cacheline adaptor side
    output logic         pmem_read_o,
    output logic         pmem_write_o,
    input  llc_cacheline pmem_rdata_i,
    input  logic         pmem_resp_i,
    output llc_cacheline pmem_wdata_o,
    output rv32i_word    pmem_address_o
);

    llc_ctrl_if ctrl_if ();

    cache_control control_i (
        .clk,
        .rst_n_i,
        .ctrl         (ctrl_if.ctrl),
        .mem_read_i,
        .mem_write_i,
        .mem_resp_o,
        .pmem_resp_i,
        .pmem_read_o,
        .pmem_write_o
    );

    cache_datapath datapath_i (
        .clk,
        .rst_n_i,
        .dp             (ctrl_if.dp),
        .mem_address_i,
        .mem_wdata_i,
        .mem_rdata_o,
        .pmem_rdata_i,
        .pmem_wdata_o,
        .pmem_address_o
    );

endmodule : cache2

// ==== rtl/cache_control.sv ====
/*
  Blocking LLC controller. One request at a time, held until mem_resp_o.
  A hit answers two cycles after the request is first seen.
  Memory strobes are held until pmem_resp_i.
*/

`timescale 1ns/1ps

module cache_control import llc_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    llc_ctrl_if.ctrl ctrl,
    input  logic     mem_read_i,
    input  logic     mem_write_i,
    output logic     mem_resp_o,
    input  logic     pmem_resp_i,
    output logic     pmem_read_o,
    output logic     pmem_write_o
);

    llc_state_t   state_q;
    llc_state_t   state_d;
    llc_way_t     hit_way;
    llc_waymask_t victim_mask;
    logic         is_hit;
    logic         victim_dirty;

    // hit vector is one-hot, so a plain scan encodes it
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ctrl.hit[w]) begin
                hit_way = llc_way_t'(w);
            end
        end
    end

    assign is_hit       = |ctrl.hit;
    assign victim_mask  = llc_waymask_t'(1) << ctrl.victim;
    assign victim_dirty = ctrl.valid[ctrl.victim] & ctrl.dirty[ctrl.victim];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d           = state_q;
        ctrl.tag_load     = '0;
        ctrl.line_load    = '0;
        ctrl.line_src_mem = 1'b0;
        ctrl.set_dirty    = 1'b0;
        ctrl.clr_dirty    = 1'b0;
        ctrl.addr_wb      = 1'b0;
        ctrl.plru_touch   = 1'b0;
        ctrl.sel_way      = ctrl.victim;
        mem_resp_o        = 1'b0;
        pmem_read_o       = 1'b0;
        pmem_write_o      = 1'b0;
        unique case (state_q)
            ST_IDLE: begin
                if (mem_read_i || mem_write_i) begin
                    state_d = ST_COMPARE;
                end
            end
            ST_COMPARE: begin
                ctrl.sel_way = hit_way;
                if (is_hit) begin
                    state_d = ST_RESPOND;
                end else if (victim_dirty) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_ALLOCATE;
                end
            end
            ST_WRITEBACK: begin
                // victim line goes out at its own address
                pmem_write_o = 1'b1;
                ctrl.addr_wb = 1'b1;
                if (pmem_resp_i) begin
                    state_d = ST_ALLOCATE;
                end
            end
            ST_ALLOCATE: begin
                pmem_read_o       = 1'b1;
                ctrl.line_src_mem = 1'b1;
                if (pmem_resp_i) begin
                    ctrl.tag_load  = victim_mask;
                    ctrl.line_load = victim_mask;
                    ctrl.clr_dirty = 1'b1;
                    state_d        = ST_COMPARE;
                end
            end
            ST_RESPOND: begin
                // address still held, so hit is still valid here
                ctrl.sel_way    = hit_way;
                ctrl.plru_touch = 1'b1;
                mem_resp_o      = 1'b1;
                if (mem_write_i) begin
                    ctrl.line_load = ctrl.hit;
                    ctrl.set_dirty = 1'b1;
                end
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

endmodule : cache_control

// ==== rtl/cache_datapath.sv ====
/*
  LLC datapath. Four ways plus the pseudo-LRU tree.
  Whole lines only; the offset bits of the request address are ignored.
  pmem addresses are always line aligned.
*/

`timescale 1ns/1ps

module cache_datapath import llc_pkg::*; import rv32i_types::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    llc_ctrl_if.dp       dp,
    input  rv32i_word    mem_address_i,
    input  llc_cacheline mem_wdata_i,
    output llc_cacheline mem_rdata_o,
    input  llc_cacheline pmem_rdata_i,
    output llc_cacheline pmem_wdata_o,
    output rv32i_word    pmem_address_o
);

    llc_tag_t     req_tag;
    llc_index_t   req_index;
    llc_tag_t     way_tag [NUM_WAYS];
    llc_cacheline way_line [NUM_WAYS];
    llc_waymask_t way_valid;
    llc_waymask_t way_dirty;
    llc_waymask_t way_hit;
    llc_cacheline line_in;
    llc_cacheline sel_line;
    llc_tag_t     addr_tag;

    assign req_index = mem_address_i[S_OFFSET +: S_INDEX];
    assign req_tag   = mem_address_i[S_OFFSET + S_INDEX +: S_TAG];

    // fills come from memory, write hits from L1
    assign line_in = dp.line_src_mem ? pmem_rdata_i : mem_wdata_i;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way way_i (
            .clk,
            .rst_n_i,
            .index_i     (req_index),
            .tag_i       (req_tag),
            .line_i      (line_in),
            .tag_load_i  (dp.tag_load[w]),
            .line_load_i (dp.line_load[w]),
            .set_dirty_i (dp.set_dirty & dp.line_load[w]),
            .clr_dirty_i (dp.clr_dirty & dp.line_load[w]),
            .tag_o       (way_tag[w]),
            .valid_o     (way_valid[w]),
            .dirty_o     (way_dirty[w]),
            .line_o      (way_line[w])
        );
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = way_valid[w] && (way_tag[w] == req_tag);
        end
    end

    assign dp.hit   = way_hit;
    assign dp.valid = way_valid;
    assign dp.dirty = way_dirty;

    plru_tree plru_i (
        .clk,
        .rst_n_i,
        .index_i     (req_index),
        .touch_i     (dp.plru_touch),
        .touch_way_i (dp.sel_way),
        .valid_i     (way_valid),
        .victim_o    (dp.victim)
    );

    // same line feeds the L1 read and the writeback
    assign sel_line     = way_line[dp.sel_way];
    assign mem_rdata_o  = sel_line;
    assign pmem_wdata_o = sel_line;

    assign addr_tag       = dp.addr_wb ? way_tag[dp.victim] : req_tag;
    assign pmem_address_o = {addr_tag, req_index, {S_OFFSET{1'b0}}};

endmodule : cache_datapath

// ==== rtl/cache_way.sv ====
/*
  One way of the LLC: tag, valid, dirty and line per set.
  Reads are combinational from index_i; writes land on the clock edge.
  Only valid and dirty are cleared by reset.
*/

`timescale 1ns/1ps

module cache_way import llc_pkg::*; import rv32i_types::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  llc_index_t   index_i,
    input  llc_tag_t     tag_i,
    input  llc_cacheline line_i,
    input  logic         tag_load_i,
    input  logic         line_load_i,
    input  logic         set_dirty_i,
    input  logic         clr_dirty_i,
    output llc_tag_t     tag_o,
    output logic         valid_o,
    output logic         dirty_o,
    output llc_cacheline line_o
);

    llc_tag_t             tags [NUM_SETS];
    llc_cacheline         lines [NUM_SETS];
    logic [NUM_SETS-1:0]  valid_q;
    logic [NUM_SETS-1:0]  dirty_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            // a tag load always comes with a fresh line
            if (tag_load_i) begin
                valid_q[index_i] <= 1'b1;
            end
            if (clr_dirty_i) begin
                dirty_q[index_i] <= 1'b0;
            end else if (set_dirty_i) begin
                dirty_q[index_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_load_i) begin
            tags[index_i] <= tag_i;
        end
        if (line_load_i) begin
            lines[index_i] <= line_i;
        end
    end

    assign tag_o   = tags[index_i];
    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];
    assign line_o  = lines[index_i];

endmodule : cache_way

// ==== rtl/llc_ctrl_if.sv ====
/*
  Control and status between the cache controller and its datapath.
  Status is combinational from the addressed set; strobes are single cycle.
*/

`timescale 1ns/1ps

interface llc_ctrl_if import llc_pkg::*; ();

    // status from the datapath
    llc_waymask_t hit;
    llc_waymask_t valid;
    llc_waymask_t dirty;
    llc_way_t     victim;

    // control from the controller
    llc_waymask_t tag_load;
    llc_waymask_t line_load;
    logic         line_src_mem;
    logic         set_dirty;
    logic         clr_dirty;
    logic         addr_wb;
    logic         plru_touch;
    llc_way_t     sel_way;

    modport ctrl (
        input  hit, valid, dirty, victim,
        output tag_load, line_load, line_src_mem, set_dirty, clr_dirty,
        output addr_wb, plru_touch, sel_way
    );

    modport dp (
        output hit, valid, dirty, victim,
        input  tag_load, line_load, line_src_mem, set_dirty, clr_dirty,
        input  addr_wb, plru_touch, sel_way
    );

endinterface : llc_ctrl_if

// ==== rtl/llc_pkg.sv ====
/*
  Geometry and types of the second-level cache.
  4 ways, 8 sets, 32-byte lines, 32-bit byte addresses.
  Changing the geometry here also needs the line type in rv32i_types.
*/

package llc_pkg;

    localparam int S_OFFSET = 5;
    localparam int S_INDEX  = 3;
    localparam int S_TAG    = 32 - S_OFFSET - S_INDEX;
    localparam int NUM_SETS = 1 << S_INDEX;
    localparam int NUM_WAYS = 4;

    typedef logic [S_TAG-1:0]           llc_tag_t;
    typedef logic [S_INDEX-1:0]         llc_index_t;
    typedef logic [$clog2(NUM_WAYS)-1:0] llc_way_t;
    // one bit per way, used for hit, valid, dirty and load strobes
    typedef logic [NUM_WAYS-1:0]        llc_waymask_t;
    // tree pseudo-LRU state of one set
    typedef logic [NUM_WAYS-2:0]        plru_bits_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_ALLOCATE,
        ST_RESPOND
    } llc_state_t;

endpackage : llc_pkg

// ==== rtl/plru_tree.sv ====
/*
  Tree pseudo-LRU, 3 bits per set for 4 ways.
  Bit 0 picks the half, bit 1 or bit 2 the way inside it.
  Invalid ways are preferred as victims, lowest first.
*/

`timescale 1ns/1ps

module plru_tree import llc_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    input  llc_index_t   index_i,
    input  logic         touch_i,
    input  llc_way_t     touch_way_i,
    input  llc_waymask_t valid_i,
    output llc_way_t     victim_o
);

    plru_bits_t bits_q [NUM_SETS];
    plru_bits_t cur;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                bits_q[s] <= '0;
            end
        end else if (touch_i) begin
            // point the path away from the touched way
            bits_q[index_i][0] <= ~touch_way_i[1];
            if (touch_way_i[1]) begin
                bits_q[index_i][2] <= ~touch_way_i[0];
            end else begin
                bits_q[index_i][1] <= ~touch_way_i[0];
            end
        end
    end

    assign cur = bits_q[index_i];

    always_comb begin
        victim_o = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_i[w]) begin
                victim_o = llc_way_t'(w);
            end
        end
    end

endmodule : plru_tree

// ==== rtl/rv32i_types.sv ====
/*
  Vector types shared across the RV32I core and its memory hierarchy.
  Addresses are byte addresses; cachelines are 32 bytes wide.
*/

package rv32i_types;

    // byte address as seen by the core and the memory side
    typedef logic [31:0] rv32i_word;

    // one full line moved between L1, LLC and main memory
    typedef logic [255:0] llc_cacheline;

endpackage : rv32i_types

// ==== src.f ====
rtl/rv32i_types.sv
rtl/llc_pkg.sv
rtl/llc_ctrl_if.sv
rtl/plru_tree.sv
rtl/cache_way.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/cache2.sv
dv/cache2_tb.sv
